// File: Makefile
TOP = tb_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f flist.f --top-module $(TOP) -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -qx "NO ERRORS" sim.log

lint:
	verilator --lint-only --timing -Wall -f flist.f --top-module core_top

clean:
	rm -rf obj_dir sim.log

// File: alu.sv
`timescale 1ns/1ps

module alu import rv_pkg::*; #(
    parameter int D_WIDTH = XLEN
) (
    input  logic [D_WIDTH-1:0] aluop1,
    input  logic [D_WIDTH-1:0] aluop2,
    input  alu_op_t            aluctrl,
    input  logic [2:0]         funct3,
    output logic [D_WIDTH-1:0] aluout,
    output logic               eq
);

localparam int SH_W = $clog2(D_WIDTH);

logic [SH_W-1:0] shamt;
logic            lt_s;
logic            lt_u;

assign shamt = aluop2[SH_W-1:0];
assign lt_s  = $signed(aluop1) < $signed(aluop2);
assign lt_u  = aluop1 < aluop2;

always_comb begin
    case (aluctrl)
        ALU_ADD:    aluout = aluop1 + aluop2;
        ALU_SUB:    aluout = aluop1 - aluop2;
        ALU_SLL:    aluout = aluop1 << shamt;
        ALU_SLT:    aluout = D_WIDTH'(lt_s);
        ALU_SLTU:   aluout = D_WIDTH'(lt_u);
        ALU_XOR:    aluout = aluop1 ^ aluop2;
        ALU_SRL:    aluout = aluop1 >> shamt;
        ALU_SRA:    aluout = $signed(aluop1) >>> shamt;
        ALU_OR:     aluout = aluop1 | aluop2;
        ALU_AND:    aluout = aluop1 & aluop2;
        ALU_PASS_B: aluout = aluop2;  // LUI.
        default:    aluout = '0;
    endcase
end

// Branch condition.
always_comb begin
    case (funct3)
        3'b000:  eq = (aluop1 == aluop2);
        3'b001:  eq = (aluop1 != aluop2);
        3'b100:  eq = lt_s;
        3'b101:  eq = !lt_s;
        3'b110:  eq = lt_u;
        3'b111:  eq = !lt_u;
        default: eq = 1'b0;
    endcase
end

endmodule

// File: core_top.sv
`timescale 1ns/1ps

module core_top import rv_pkg::*; #(
    parameter int D_WIDTH = XLEN
) (
    input  logic        clk,
    input  logic        arst_n,
    output logic        fetch_req,
    output logic [31:0] fetch_addr,
    input  logic        fetch_ack,
    input  logic [31:0] fetch_data,
    output wb_t         retire
);

fd_t                fd_d;
fd_t                fd_q;
de_t                de_d;
de_t                de_q;
wb_t                mem_d;
wb_t                mem_q;
wb_t                wb_q;
ctrl_t              ctrl_d;
logic [D_WIDTH-1:0] imm_d;
logic [4:0]         rs1_d;
logic [4:0]         rs2_d;
logic [4:0]         rd_d;
logic [D_WIDTH-1:0] rd1_d;
logic [D_WIDTH-1:0] rd2_d;
logic               pc_src;
logic [D_WIDTH-1:0] alu_result_e;
logic [D_WIDTH-1:0] pc_target_e;
fwd_sel_t           fwd_rs1;
fwd_sel_t           fwd_rs2;
logic               flush;

fetch u_fetch (
    .clk         (clk),
    .arst_n      (arst_n),
    .redirect    (pc_src),
    .redirect_pc (pc_target_e),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .fetch_ack   (fetch_ack),
    .fetch_data  (fetch_data),
    .fd          (fd_d)
);

decode #(.D_WIDTH(D_WIDTH)) u_decode (
    .fd      (fd_q),
    .de_ctrl (ctrl_d),
    .imm_ext (imm_d),
    .rs1     (rs1_d),
    .rs2     (rs2_d),
    .rd      (rd_d)
);

regfile #(.D_WIDTH(D_WIDTH)) u_regfile (
    .clk    (clk),
    .arst_n (arst_n),
    .rs1    (rs1_d),
    .rs2    (rs2_d),
    .rd1    (rd1_d),
    .rd2    (rd2_d),
    .wb     (wb_q)
);

execute #(.D_WIDTH(D_WIDTH)) u_execute (
    .de           (de_q),
    .result_w     (wb_q.result),
    .alu_result_m (mem_q.result),
    .fwd_rs1      (fwd_rs1),
    .fwd_rs2      (fwd_rs2),
    .pc_src       (pc_src),
    .alu_result   (alu_result_e),
    .pc_target    (pc_target_e)
);

hazard_unit u_hazard (
    .de      (de_q),
    .mem     (mem_q),
    .wb      (wb_q),
    .pc_src  (pc_src),
    .fwd_rs1 (fwd_rs1),
    .fwd_rs2 (fwd_rs2),
    .flush   (flush)
);

// Stage records -----------------
always_comb begin
    de_d.valid   = fd_q.valid;
    de_d.ctrl    = ctrl_d;
    de_d.pc      = fd_q.pc;
    de_d.rd1     = rd1_d;
    de_d.rd2     = rd2_d;
    de_d.imm_ext = imm_d;
    de_d.rs1     = rs1_d;
    de_d.rs2     = rs2_d;
    de_d.rd      = rd_d;

    mem_d.valid     = de_q.valid;
    mem_d.reg_write = de_q.ctrl.reg_write;
    mem_d.rd        = de_q.rd;
    mem_d.pc        = de_q.pc;
    mem_d.result    = alu_result_e;
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        fd_q.valid  <= 1'b0;
        de_q.valid  <= 1'b0;
        mem_q.valid <= 1'b0;
        wb_q.valid  <= 1'b0;
    end else begin
        fd_q  <= fd_d;
        de_q  <= de_d;
        mem_q <= mem_d;  // The redirecting instruction itself moves on.
        wb_q  <= mem_q;
        if (flush) begin
            fd_q.valid <= 1'b0;
            de_q.valid <= 1'b0;
        end
    end
end

assign retire = wb_q;

endmodule

// File: decode.sv
`timescale 1ns/1ps

module decode import rv_pkg::*; #(
    parameter int D_WIDTH = XLEN
) (
    input  fd_t                fd,
    output ctrl_t              de_ctrl,
    output logic [D_WIDTH-1:0] imm_ext,
    output logic [4:0]         rs1,
    output logic [4:0]         rs2,
    output logic [4:0]         rd
);

logic [6:0]  opcode;
logic [31:0] imm32;

function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt, input logic is_reg);
    case (f3)
        3'b000:  return (is_reg && alt) ? ALU_SUB : ALU_ADD;
        3'b001:  return ALU_SLL;
        3'b010:  return ALU_SLT;
        3'b011:  return ALU_SLTU;
        3'b100:  return ALU_XOR;
        3'b101:  return alt ? ALU_SRA : ALU_SRL;
        3'b110:  return ALU_OR;
        default: return ALU_AND;
    endcase
endfunction

assign opcode  = fd.instr.r.opcode;
assign rs1     = fd.instr.r.rs1;
assign rs2     = fd.instr.r.rs2;
assign rd      = fd.instr.r.rd;
assign imm_ext = D_WIDTH'($signed(imm32));

always_comb begin
    de_ctrl        = '0;
    de_ctrl.funct3 = fd.instr.r.funct3;
    imm32          = '0;

    if (fd.valid) begin
        case (opcode)
            OP_REG: begin
                de_ctrl.alu_ctrl  = alu_sel(fd.instr.r.funct3, fd.instr.r.funct7[5], 1'b1);
                de_ctrl.rs1_used  = 1'b1;
                de_ctrl.rs2_used  = 1'b1;
                de_ctrl.reg_write = 1'b1;
            end
            OP_IMM: begin
                de_ctrl.alu_ctrl  = alu_sel(fd.instr.i.funct3, fd.instr.r.funct7[5], 1'b0);
                de_ctrl.alu_src   = 1'b1;
                de_ctrl.rs1_used  = 1'b1;
                de_ctrl.reg_write = 1'b1;
                imm32             = 32'($signed(fd.instr.i.imm));
            end
            OP_LUI, OP_AUIPC: begin
                de_ctrl.alu_ctrl  = (opcode == OP_LUI) ? ALU_PASS_B : ALU_ADD;
                de_ctrl.op1_pc    = (opcode == OP_AUIPC);
                de_ctrl.alu_src   = 1'b1;
                de_ctrl.reg_write = 1'b1;
                imm32             = {fd.instr.u.imm, 12'b0};
            end
            OP_JAL: begin
                de_ctrl.jump      = 1'b1;
                de_ctrl.op1_pc    = 1'b1;
                de_ctrl.reg_write = 1'b1;
                imm32 = 32'($signed({fd.instr.j.imm20, fd.instr.j.imm19_12, fd.instr.j.imm11,
                                     fd.instr.j.imm10_1, 1'b0}));
            end
            OP_JALR: begin
                de_ctrl.jump      = 1'b1;
                de_ctrl.jalr      = 1'b1;
                de_ctrl.alu_src   = 1'b1;
                de_ctrl.rs1_used  = 1'b1;
                de_ctrl.reg_write = 1'b1;
                imm32             = 32'($signed(fd.instr.i.imm));
            end
            OP_BRANCH: begin
                de_ctrl.alu_ctrl = ALU_SUB;
                de_ctrl.branch   = 1'b1;
                de_ctrl.rs1_used = 1'b1;
                de_ctrl.rs2_used = 1'b1;
                imm32 = 32'($signed({fd.instr.b.imm12, fd.instr.b.imm11, fd.instr.b.imm10_5,
                                     fd.instr.b.imm4_1, 1'b0}));
            end
            default: ;  // Unknown opcode retires as a no-op.
        endcase
    end
end

endmodule

// File: execute.sv
`timescale 1ns/1ps

module execute import rv_pkg::*; #(
    parameter int D_WIDTH = XLEN
) (
    input  de_t                de,
    input  logic [D_WIDTH-1:0] result_w,
    input  logic [D_WIDTH-1:0] alu_result_m,
    input  fwd_sel_t           fwd_rs1,
    input  fwd_sel_t           fwd_rs2,
    output logic               pc_src,
    output logic [D_WIDTH-1:0] alu_result,
    output logic [D_WIDTH-1:0] pc_target
);

logic [D_WIDTH-1:0] fwd_a;
logic [D_WIDTH-1:0] fwd_b;
logic [D_WIDTH-1:0] src_a;
logic [D_WIDTH-1:0] src_b;
logic [D_WIDTH-1:0] alu_res;
logic [D_WIDTH-1:0] pc_imm;
logic               cond;

function automatic logic [D_WIDTH-1:0] fwd_pick(input fwd_sel_t sel,
                                                input logic [D_WIDTH-1:0] reg_val);
    case (sel)
        FWD_WB:  return result_w;
        FWD_MEM: return alu_result_m;
        default: return reg_val;
    endcase
endfunction

// Operand select ----------------
assign fwd_a = de.ctrl.rs1_used ? fwd_pick(fwd_rs1, de.rd1) : '0;
assign fwd_b = de.ctrl.rs2_used ? fwd_pick(fwd_rs2, de.rd2) : '0;
assign src_a = de.ctrl.op1_pc ? de.pc : fwd_a;
assign src_b = de.ctrl.alu_src ? de.imm_ext : fwd_b;

alu #(.D_WIDTH(D_WIDTH)) u_alu (
    .aluop1  (src_a),
    .aluop2  (src_b),
    .aluctrl (de.ctrl.alu_ctrl),
    .funct3  (de.ctrl.funct3),
    .aluout  (alu_res),
    .eq      (cond)
);

// Control flow ------------------
assign pc_imm     = de.pc + de.imm_ext;
assign pc_target  = de.ctrl.jalr ? {alu_res[D_WIDTH-1:1], 1'b0} : pc_imm;
assign pc_src     = de.valid && (de.ctrl.jump || (de.ctrl.branch && cond));
assign alu_result = de.ctrl.jump ? de.pc + D_WIDTH'(4) : alu_res;  // Link value.

endmodule

// File: fetch.sv
`timescale 1ns/1ps

module fetch import rv_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    output logic        fetch_req,
    output logic [31:0] fetch_addr,
    input  logic        fetch_ack,
    input  logic [31:0] fetch_data,
    output fd_t         fd
);

typedef enum logic {S_IDLE, S_REQ} state_t;

state_t      state;
logic [31:0] addr_q;
logic [31:0] pend_pc;   // Target taken while a word was in flight.
logic        discard;
logic        accept;
logic        hold;

assign accept     = (state == S_REQ) && fetch_ack;
assign hold       = (state == S_REQ) && !fetch_ack;
assign fetch_req  = (state == S_REQ);
assign fetch_addr = addr_q;

assign fd.valid = accept && !discard;
assign fd.pc    = addr_q;
assign fd.instr = fetch_data;

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        state   <= S_IDLE;
        addr_q  <= RESET_PC;
        discard <= 1'b0;
    end else begin
        case (state)
            S_IDLE:  if (!fetch_ack) state <= S_REQ;  // Wait for ack to drop.
            S_REQ:   if (fetch_ack) state <= S_IDLE;
            default: state <= S_IDLE;
        endcase

        // Address must stay stable while req is up.
        if (redirect && !hold) begin
            addr_q <= redirect_pc;
        end else if (accept) begin
            addr_q <= discard ? pend_pc : addr_q + 32'd4;
        end

        if (redirect && hold) begin
            discard <= 1'b1;
        end else if (accept) begin
            discard <= 1'b0;
        end
    end
end

always_ff @(posedge clk) begin
    if (redirect) pend_pc <= redirect_pc;
end

endmodule

// File: flist.f
rv_pkg.sv
fetch.sv
decode.sv
regfile.sv
alu.sv
execute.sv
hazard_unit.sv
core_top.sv
tb_clkgen.sv
tb_core.sv

// File: hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import rv_pkg::*; (
    input  de_t      de,
    input  wb_t      mem,
    input  wb_t      wb,
    input  logic     pc_src,
    output fwd_sel_t fwd_rs1,
    output fwd_sel_t fwd_rs2,
    output logic     flush
);

function automatic logic hit(input wb_t stg, input logic [4:0] rs, input logic used);
    return used && (rs != 5'd0) && stg.valid && stg.reg_write && (stg.rd == rs);
endfunction

// Memory stage is the younger result and wins.
assign fwd_rs1 = hit(mem, de.rs1, de.ctrl.rs1_used) ? FWD_MEM :
                 hit(wb, de.rs1, de.ctrl.rs1_used)  ? FWD_WB  : FWD_REG;
assign fwd_rs2 = hit(mem, de.rs2, de.ctrl.rs2_used) ? FWD_MEM :
                 hit(wb, de.rs2, de.ctrl.rs2_used)  ? FWD_WB  : FWD_REG;

assign flush = pc_src;  // Drop decode and execute on redirect.

endmodule

// File: regfile.sv
`timescale 1ns/1ps

module regfile import rv_pkg::*; #(
    parameter int D_WIDTH = XLEN
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic [4:0]         rs1,
    input  logic [4:0]         rs2,
    output logic [D_WIDTH-1:0] rd1,
    output logic [D_WIDTH-1:0] rd2,
    input  wb_t                wb
);

logic [D_WIDTH-1:0] regs [1:31];
logic               we;

assign we = wb.valid && wb.reg_write && (wb.rd != 5'd0);

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
        end
    end else if (we) begin
        regs[wb.rd] <= wb.result;
    end
end

// x0 reads zero, a same-cycle write is passed through.
assign rd1 = (rs1 == 5'd0) ? '0 : (we && wb.rd == rs1) ? wb.result : regs[rs1];
assign rd2 = (rs2 == 5'd0) ? '0 : (we && wb.rd == rs2) ? wb.result : regs[rs2];

endmodule

// File: rv_pkg.sv
package rv_pkg;

    localparam int XLEN = 32;
    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    // Opcodes ------------------------
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_REG = 2'b00,
        FWD_WB  = 2'b01,
        FWD_MEM = 2'b10
    } fwd_sel_t;

    // Instruction formats ------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    // Stage records ------------------
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        instr_u      instr;
    } fd_t;

    typedef struct packed {
        alu_op_t    alu_ctrl;
        logic       alu_src;
        logic       op1_pc;
        logic       jump;
        logic       branch;
        logic       jalr;
        logic       rs1_used;
        logic       rs2_used;
        logic       reg_write;
        logic [2:0] funct3;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        ctrl_t           ctrl;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rd1;
        logic [XLEN-1:0] rd2;
        logic [XLEN-1:0] imm_ext;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
    } de_t;

    typedef struct packed {
        logic            valid;
        logic            reg_write;
        logic [4:0]      rd;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] result;
    } wb_t;

endpackage

// File: tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic arst_n
);

initial begin
    clk    = 1'b0;
    arst_n = 1'b0;
    repeat (3) @(posedge clk);
    #1 arst_n = 1'b1;  // Released between edges.
end

always #2 clk = ~clk;  // 4 ns period.

endmodule

// File: tb_core.sv
`timescale 1ns/1ps

module tb_core import rv_pkg::*; ();

localparam int          PROG_LEN   = 200;
localparam int          NUM_RET    = 200;
localparam int          MAX_CYCLES = 6000;
localparam int          RSP_LIMIT  = 16;
localparam logic [31:0] NOP_WORD   = 32'h0000_0013;  // ADDI x0, x0, 0.

logic        clk;
logic        arst_n;
logic        fetch_req;
logic [31:0] fetch_addr;
logic        fetch_ack;
logic [31:0] fetch_data;
wb_t         retire;

integer      seed;
logic [31:0] prog [0:PROG_LEN-1];
wb_t         exp_q [$];
logic        req_prev;
int          rsp_state;  // 0 idle, 1 delay, 2 ack high, 3 ack held after req drop.
int          rsp_delay;
int          rsp_wait;
int          n_ret;
int          cycles;

tb_clkgen u_clkgen (
    .clk    (clk),
    .arst_n (arst_n)
);

core_top #(.D_WIDTH(XLEN)) UUT (
    .clk        (clk),
    .arst_n     (arst_n),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .fetch_ack  (fetch_ack),
    .fetch_data (fetch_data),
    .retire     (retire)
);

// Helpers -----------------------
function automatic int rand_below(input int n);
    return int'({$random(seed)} % n);
endfunction

function automatic logic [31:0] word_at(input logic [31:0] addr);
    if (addr[31:2] < 30'(PROG_LEN)) begin
        return prog[addr[9:2]];
    end
    return NOP_WORD;  // Past the end of the program.
endfunction

function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return {31'd0, $signed(a) < $signed(b)};
        3'd3:    return {31'd0, a < b};
        3'd4:    return a ^ b;
        3'd5: begin
            if (alt) begin
                return $signed(a) >>> b[4:0];
            end
            return a >> b[4:0];
        end
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
        3'd0:    return a == b;
        3'd1:    return a != b;
        3'd4:    return $signed(a) < $signed(b);
        3'd5:    return $signed(a) >= $signed(b);
        3'd6:    return a < b;
        default: return a >= b;
    endcase
endfunction

function automatic string wb_text(input wb_t r);
    return $sformatf("pc=%h rd=%0d we=%b result=%h", r.pc, r.rd, r.reg_write, r.result);
endfunction

task automatic abort_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
endtask

// Checks ------------------------
task automatic compare_retire(input string name, input wb_t want, input wb_t got);
    logic bad;
    bad = (got.valid !== want.valid) || (got.pc !== want.pc) ||
          (got.reg_write !== want.reg_write);
    if (want.reg_write) begin
        bad = bad || (got.rd !== want.rd) || (got.result !== want.result);
    end
    if (bad) begin
        abort_run($sformatf("MISMATCH %s: expected %s, actual %s", name,
                            wb_text(want), wb_text(got)));
    end
endtask

task automatic check_pc(input string name, input logic [31:0] want, input logic [31:0] got);
    if (got !== want) begin
        abort_run($sformatf("MISMATCH %s: expected %h, actual %h", name, want, got));
    end
endtask

task automatic expect_bit(input string name, input logic want, input logic got);
    if (got !== want) begin
        abort_run($sformatf("MISMATCH %s: expected %b, actual %b", name, want, got));
    end
endtask

// Program and model -------------
task automatic build_program();
    instr_u      w;
    int          kind;
    int          k;
    logic [31:0] off;
    logic [2:0]  f3;
    for (int i = 0; i < PROG_LEN; i++) begin
        w    = '0;
        kind = rand_below(16);
        k    = 1 + rand_below(8);
        off  = 32'(4 * k);
        f3   = 3'(rand_below(8));
        if (kind >= 13 && i + 8 >= PROG_LEN) begin
            kind = 6;  // Keep targets inside the program.
        end
        w.r.rd  = 5'(rand_below(8));  // Few registers, many dependencies.
        w.r.rs1 = 5'(rand_below(8));
        if (kind < 6) begin
            w.r.opcode = OP_REG;
            w.r.funct3 = f3;
            w.r.rs2    = 5'(rand_below(8));
            w.r.funct7 = (f3 == 3'd0 || f3 == 3'd5) ? 7'(rand_below(2) << 5) : 7'd0;
        end else if (kind < 11) begin
            w.i.opcode = OP_IMM;
            w.i.funct3 = f3;
            if (f3 == 3'd1) begin
                w.i.imm = 12'(rand_below(32));
            end else if (f3 == 3'd5) begin
                w.i.imm = 12'(rand_below(32) + (rand_below(2) << 10));
            end else begin
                w.i.imm = 12'(rand_below(4096));
            end
        end else if (kind < 13) begin
            w.u.opcode = (kind == 11) ? OP_LUI : OP_AUIPC;
            w.u.imm    = 20'($random(seed));
        end else if (kind == 13) begin
            w.b.opcode  = OP_BRANCH;
            w.b.funct3  = (f3 == 3'd2 || f3 == 3'd3) ? 3'd0 : f3;
            w.b.rs2     = 5'(rand_below(8));
            w.b.imm12   = off[12];
            w.b.imm11   = off[11];
            w.b.imm10_5 = off[10:5];
            w.b.imm4_1  = off[4:1];
        end else if (kind == 14) begin
            w.j.opcode   = OP_JAL;
            w.j.imm20    = off[20];
            w.j.imm19_12 = off[19:12];
            w.j.imm11    = off[11];
            w.j.imm10_1  = off[10:1];
        end else begin
            w.i.opcode = OP_JALR;  // Absolute target from x0.
            w.i.rs1    = 5'd0;
            w.i.funct3 = 3'd0;
            w.i.imm    = 12'(4 * (i + k));
        end
        prog[i] = w;
    end
endtask

task automatic run_model();
    logic [31:0] xreg [0:31];
    logic [31:0] pc;
    logic [31:0] nxt;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] i_imm;
    instr_u      w;
    wb_t         e;
    for (int r = 0; r < 32; r++) begin
        xreg[r] = '0;
    end
    pc = RESET_PC;
    while (exp_q.size() < NUM_RET) begin
        w           = word_at(pc);
        a           = xreg[w.r.rs1];
        b           = xreg[w.r.rs2];
        i_imm       = {{20{w.i.imm[11]}}, w.i.imm};
        nxt         = pc + 32'd4;
        e           = '0;
        e.valid     = 1'b1;
        e.pc        = pc;
        e.rd        = w.r.rd;
        e.reg_write = 1'b1;
        case (w.r.opcode)
            OP_REG:   e.result = ref_alu(w.r.funct3, w.r.funct7[5], a, b);
            OP_IMM:   e.result = ref_alu(w.i.funct3, w.i.funct3 == 3'd5 && w.i.imm[10], a, i_imm);
            OP_LUI:   e.result = {w.u.imm, 12'h000};
            OP_AUIPC: e.result = pc + {w.u.imm, 12'h000};
            OP_JAL: begin
                e.result = pc + 32'd4;
                nxt = pc + {{11{w.j.imm20}}, w.j.imm20, w.j.imm19_12, w.j.imm11,
                            w.j.imm10_1, 1'b0};
            end
            OP_JALR: begin
                e.result = pc + 32'd4;
                nxt      = (a + i_imm) & ~32'd1;
            end
            OP_BRANCH: begin
                e.reg_write = 1'b0;
                if (branch_taken(w.b.funct3, a, b)) begin
                    nxt = pc + {{19{w.b.imm12}}, w.b.imm12, w.b.imm11, w.b.imm10_5,
                                w.b.imm4_1, 1'b0};
                end
            end
            default: e.reg_write = 1'b0;
        endcase
        if (e.reg_write && e.rd != 5'd0) begin
            xreg[e.rd] = e.result;
        end
        exp_q.push_back(e);
        pc = nxt;
    end
endtask

// Memory responder and checker --
task automatic raise_ack();
    fetch_ack  = 1'b1;
    fetch_data = word_at(fetch_addr);
    rsp_state  = 2;
    rsp_wait   = 0;
endtask

task automatic drop_ack();
    fetch_ack = 1'b0;  // Fourth phase.
    rsp_state = 0;
    rsp_wait  = 0;
endtask

task automatic service_cycle();
    wb_t want;
    if (fetch_req && !req_prev && fetch_ack) begin
        abort_run("handshake violation: fetch_req rose while fetch_ack was still high");
    end
    req_prev = fetch_req;

    if (retire.valid) begin
        want = exp_q.pop_front();
        compare_retire($sformatf("retire %0d", n_ret), want, retire);
        n_ret++;
    end

    case (rsp_state)
        0: begin
            rsp_wait++;
            if (fetch_req) begin
                rsp_delay = rand_below(4);
                if (rsp_delay == 0) begin
                    raise_ack();
                end else begin
                    rsp_state = 1;
                end
            end else if (rsp_wait > RSP_LIMIT) begin
                abort_run("fetch_req never rose for the next instruction");
            end
        end
        1: begin
            rsp_delay--;
            if (rsp_delay == 0) begin
                raise_ack();
            end
        end
        2: begin
            rsp_wait++;
            if (!fetch_req) begin
                rsp_delay = rand_below(4);  // Memory may hold ack a while.
                if (rsp_delay == 0) begin
                    drop_ack();
                end else begin
                    rsp_state = 3;
                end
            end else if (rsp_wait > RSP_LIMIT) begin
                abort_run("fetch_req stayed high after fetch_ack");
            end
        end
        default: begin
            rsp_delay--;
            if (rsp_delay == 0) begin
                drop_ack();
            end
        end
    endcase
endtask

initial begin
    fetch_ack  = 1'b0;
    fetch_data = '0;
    seed       = 32'hc64d;
    req_prev   = 1'b0;
    rsp_state  = 0;
    rsp_delay  = 0;
    rsp_wait   = 0;
    n_ret      = 0;
    cycles     = 0;
    build_program();
    run_model();

    @(negedge clk);
    while (!arst_n) begin
        expect_bit("fetch_req in reset", 1'b0, fetch_req);
        expect_bit("retire.valid in reset", 1'b0, retire.valid);
        cycles++;
        if (cycles > 10) begin
            abort_run("reset was never released");
        end
        @(negedge clk);
    end
    expect_bit("fetch_req after reset", 1'b0, fetch_req);
    expect_bit("retire.valid after reset", 1'b0, retire.valid);

    @(negedge clk);
    expect_bit("first fetch_req", 1'b1, fetch_req);
    check_pc("first fetch_addr", 32'h0000_0000, fetch_addr);

    cycles = 0;
    while (n_ret < NUM_RET) begin
        service_cycle();
        cycles++;
        if (cycles > MAX_CYCLES) begin
            abort_run($sformatf("timeout with %0d of %0d retirements seen", n_ret, NUM_RET));
        end
        @(negedge clk);
    end
    $display("NO ERRORS");
    $finish;
end

endmodule
